/* files.f */
+incdir+include
rtl/periph_pkg.sv
rtl/req_fifo.sv
rtl/apb_bridge.sv
rtl/soc_ctrl_regs.sv
rtl/apb_stdout.sv
rtl/periph_subsys.sv
sim/tb_periph_subsys.sv

/* Makefile */
SIM := obj_dir/Vtb_periph_subsys
SRCS := $(shell grep -v '^+' files.f) include/periph_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) files.f
	verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
		-f files.f --top-module tb_periph_subsys

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_periph_subsys.sv */
// Testbench for the peripheral subsystem
// Clock, reset, directed and random host requests, a reference model
// of the register map and stdout port, and checking assertions

`timescale 1ns/1ns
`include "periph_consts.svh"

module tb_periph_subsys
  import periph_pkg::*;
;

  localparam int unsigned SEED       = 32'ha951_926e;
  localparam int unsigned SAT_CHARS  = 260;
  localparam int unsigned N_DIRECTED = 64;
  localparam int unsigned N_RANDOM   = 400;
  localparam int unsigned MAX_GAP    = 6;
  // Worst case per request is a full drain plus an idle gap
  localparam int unsigned LIMIT_CYCLES =
    16 + (SAT_CHARS + N_DIRECTED + N_RANDOM) * (3 + 4 + MAX_GAP) + 200;

  typedef struct packed {
    int unsigned                cycle;
    data_t                      rdata;
    logic                       err;
    logic                       chr;
    core_id_t                   core;
    logic [7:0]                 data;
    logic                       eol;
    logic [`PERIPH_N_CORES-1:0] fetch;
    logic                       eoc;
    data_t                      exit_code;
  } exp_rsp_t;

  logic clk;
  logic rst;
  logic req_valid;
  logic req_write;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_strb;
  logic rsp_valid;
  data_t rsp_rdata;
  logic rsp_err;
  logic [`PERIPH_N_CORES-1:0] fetch_en;
  logic eoc;
  data_t exit_code;
  logic char_valid;
  core_id_t char_core;
  logic [7:0] char_data;
  logic line_end;

  // Reference model state, updated in request order
  exp_rsp_t exp_q[$];
  exp_rsp_t head;
  logic head_pend;
  logic [`PERIPH_N_CORES-1:0] m_fetch;
  data_t m_scratch;
  logic m_eoc;
  data_t m_exit;
  cnt_t m_cnt [`PERIPH_N_CORES];
  int unsigned last_rsp_cycle;
  int unsigned cycle_cnt;
  int unsigned n_req;
  int unsigned n_rsp_seen;
  logic pop_pending;

  periph_subsys dut_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .req_valid_i  (req_valid),
    .req_write_i  (req_write),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_strb_i   (req_strb),
    .rsp_valid_o  (rsp_valid),
    .rsp_rdata_o  (rsp_rdata),
    .rsp_err_o    (rsp_err),
    .fetch_en_o   (fetch_en),
    .eoc_o        (eoc),
    .exit_code_o  (exit_code),
    .char_valid_o (char_valid),
    .char_core_o  (char_core),
    .char_data_o  (char_data),
    .line_end_o   (line_end)
  );

  always #2 clk = ~clk;

  function automatic void report_error(input string msg);
    $display("error %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endfunction

  function automatic void refresh_head();
    head_pend = (exp_q.size() != 0);
    head      = head_pend ? exp_q[0] : '0;
  endfunction

  // Responses are taken off the model at the edge that ends the strobe
  always @(negedge clk) begin
    pop_pending = rsp_valid;
    if (rsp_valid) begin
      n_rsp_seen++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (pop_pending && exp_q.size() != 0) begin
      exp_q.delete(0);
      refresh_head();
    end
    pop_pending = 1'b0;
  end

  // Expected response for one request, from the address map rules
  task automatic model_request(input logic wr, input addr_t addr, input data_t wdata,
                               input strb_t strb);
    exp_rsp_t e;
    logic [11:0] off;
    logic [7:0] slot;
    core_id_t c;
    off  = addr[11:0];
    slot = off[11:4];
    c    = off[5:4];
    e    = '0;
    e.err = 1'b1;
    // Idle bridge answers 3 cycles after the request edge, busy one every 3
    e.cycle = (cycle_cnt + 4 > last_rsp_cycle + 3) ? cycle_cnt + 4 : last_rsp_cycle + 3;
    last_rsp_cycle = e.cycle;
    if (addr >= `CTRL_BASE && addr <= `CTRL_END) begin
      e.err = 1'b0;
      case (off)
        `REG_INFO: begin
          if (wr) begin
            e.err = 1'b1;
          end else begin
            // One cluster, four cores
            e.rdata = 32'h0001_0004;
          end
        end
        `REG_FETCH_EN: begin
          if (wr) begin
            m_fetch = wdata[`PERIPH_N_CORES-1:0];
          end else begin
            e.rdata = data_t'(m_fetch);
          end
        end
        `REG_SCRATCH: begin
          if (wr) begin
            for (int b = 0; b < 4; b++) begin
              if (strb[b]) begin
                m_scratch[8*b +: 8] = wdata[8*b +: 8];
              end
            end
          end else begin
            e.rdata = m_scratch;
          end
        end
        `REG_EOC: begin
          if (wr) begin
            m_eoc  = 1'b1;
            m_exit = wdata;
          end else begin
            e.rdata = m_exit;
          end
        end
        default: e.err = 1'b1;
      endcase
    end else if (addr >= `STDOUT_BASE && addr <= `STDOUT_END) begin
      if (off[3:0] == 4'h0 && slot < 8'(`PERIPH_N_CORES)) begin
        e.err = 1'b0;
        if (wr) begin
          e.chr  = 1'b1;
          e.core = c;
          e.data = wdata[7:0];
          e.eol  = (wdata[7:0] == 8'h0A);
          if (e.eol) begin
            m_cnt[c] = '0;
          end else if (m_cnt[c] != 8'd255) begin
            m_cnt[c] = m_cnt[c] + 8'd1;
          end
        end else begin
          e.rdata = data_t'(m_cnt[c]);
        end
      end
    end
    e.fetch     = m_fetch;
    e.eoc       = m_eoc;
    e.exit_code = m_exit;
    exp_q.push_back(e);
    refresh_head();
  endtask

  task automatic step_idle();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      step_idle();
    end
  endtask

  task automatic issue_req(input logic wr, input addr_t addr, input data_t wdata,
                           input strb_t strb);
    // Host keeps at most a queue's worth of requests outstanding
    while (exp_q.size() >= `REQ_DEPTH) begin
      step_idle();
    end
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wdata;
    req_strb  = strb;
    n_req++;
    model_request(wr, addr, wdata, strb);
  endtask

  task automatic lone_req(input logic wr, input addr_t addr, input data_t wdata,
                          input strb_t strb);
    drain();
    step_idle();
    issue_req(wr, addr, wdata, strb);
  endtask

  task automatic put_char(input int unsigned core, input logic [7:0] ch);
    data_t w;
    w      = $urandom;
    w[7:0] = ch;
    issue_req(1'b1, `STDOUT_BASE + addr_t'(16 * core), w, 4'hF);
  endtask

  task automatic read_count(input int unsigned core);
    issue_req(1'b0, `STDOUT_BASE + addr_t'(16 * core), '0, '0);
  endtask

  task automatic random_request();
    int unsigned kind;
    logic [11:0] off;
    logic [7:0] ch;
    kind = $urandom_range(9);
    case (kind)
      0, 1, 2: begin
        case ($urandom_range(3))
          0: off = `REG_INFO;
          1: off = `REG_FETCH_EN;
          2: off = `REG_SCRATCH;
          default: off = `REG_EOC;
        endcase
        issue_req(kind == 2, `CTRL_BASE + addr_t'(off), $urandom, strb_t'($urandom_range(15)));
      end
      3: begin
        off = 12'h010 + 12'($urandom_range(12'hFEF));
        issue_req(1'($urandom_range(1)), `CTRL_BASE + addr_t'(off), $urandom, 4'hF);
      end
      4, 5, 6: begin
        ch = ($urandom_range(7) == 0) ? 8'h0A : 8'(32 + $urandom_range(94));
        put_char($urandom_range(3), ch);
      end
      7: read_count($urandom_range(3));
      8: begin
        if ($urandom_range(1) == 1) begin
          off = 12'h040 + 12'($urandom_range(12'hFBF));
        end else begin
          off = {6'h00, 2'($urandom_range(3)), 4'(1 + $urandom_range(14))};
        end
        issue_req(1'($urandom_range(1)), `STDOUT_BASE + addr_t'(off), $urandom, 4'hF);
      end
      default: issue_req(1'($urandom_range(1)), {4'h0, 28'($urandom)}, $urandom, 4'hF);
    endcase
  endtask

  a_rsp_expected: assert property (@(negedge clk) disable iff (rst)
    rsp_valid |-> head_pend)
    else report_error("response strobe with no request outstanding");

  a_rsp_timing: assert property (@(negedge clk) disable iff (rst)
    rsp_valid |-> (cycle_cnt == head.cycle))
    else report_error("response strobe in the wrong cycle");

  a_rsp_missing: assert property (@(negedge clk) disable iff (rst)
    (head_pend && cycle_cnt == head.cycle) |-> rsp_valid)
    else report_error("expected response did not arrive");

  a_rsp_value: assert property (@(negedge clk) disable iff (rst)
    rsp_valid |-> (rsp_rdata == head.rdata && rsp_err == head.err))
    else report_error("wrong response data or error flag");

  a_char_event: assert property (@(negedge clk) disable iff (rst)
    rsp_valid |-> (char_valid == head.chr && line_end == head.eol &&
                   (!head.chr || (char_core == head.core && char_data == head.data))))
    else report_error("wrong stdout character or line end");

  a_no_stray_char: assert property (@(negedge clk) disable iff (rst)
    !rsp_valid |-> (!char_valid && !line_end))
    else report_error("stdout strobe outside a response cycle");

  a_ctrl_state: assert property (@(negedge clk) disable iff (rst)
    rsp_valid |-> (fetch_en == head.fetch && eoc == head.eoc && exit_code == head.exit_code))
    else report_error("wrong fetch enable, eoc or exit code");

  a_reset_state: assert property (@(negedge clk)
    $fell(rst) |-> (fetch_en == '0 && !eoc && exit_code == '0 && !rsp_valid && !char_valid))
    else report_error("outputs not cleared by reset");

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", LIMIT_CYCLES);
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    rst = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    req_strb  = '0;
    m_fetch = '0;
    m_scratch = '0;
    m_eoc = 1'b0;
    m_exit = '0;
    for (int c = 0; c < `PERIPH_N_CORES; c++) begin
      m_cnt[c] = '0;
    end
    last_rsp_cycle = 0;
    cycle_cnt = 0;
    n_req = 0;
    n_rsp_seen = 0;
    pop_pending = 1'b0;
    refresh_head();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Lone requests into an empty queue
    lone_req(1'b0, `CTRL_BASE + `REG_INFO, '0, '0);
    lone_req(1'b1, `CTRL_BASE + `REG_SCRATCH, 32'hA5A5_5A5A, 4'hF);
    lone_req(1'b1, `CTRL_BASE + `REG_SCRATCH, 32'h1122_3344, 4'b0101);
    lone_req(1'b0, `CTRL_BASE + `REG_SCRATCH, '0, '0);
    issue_req(1'b1, `CTRL_BASE + `REG_FETCH_EN, 32'hFFFF_FFF5, 4'hF);
    issue_req(1'b0, `CTRL_BASE + `REG_FETCH_EN, '0, '0);
    issue_req(1'b1, `CTRL_BASE + `REG_SCRATCH, 32'hDEAD_BEEF, 4'b1000);
    issue_req(1'b0, `CTRL_BASE + `REG_SCRATCH, '0, '0);

    // Error cases, then read back that nothing changed
    issue_req(1'b1, `CTRL_BASE + `REG_INFO, 32'h1234_5678, 4'hF);
    issue_req(1'b1, `CTRL_BASE + 32'h010, 32'h0000_00FF, 4'hF);
    issue_req(1'b0, `CTRL_BASE + 32'h006, '0, '0);
    issue_req(1'b1, `STDOUT_BASE + 32'h004, 32'h41, 4'hF);
    issue_req(1'b1, `STDOUT_BASE + 32'h040, 32'h42, 4'hF);
    issue_req(1'b0, `STDOUT_BASE + 32'h108, '0, '0);
    issue_req(1'b1, 32'h1A10_5000, 32'h0000_0003, 4'hF);
    issue_req(1'b0, 32'h0000_0000, '0, '0);
    issue_req(1'b1, 32'h1A10_3FFC, 32'h0000_0001, 4'hF);
    issue_req(1'b0, `CTRL_BASE + `REG_INFO, '0, '0);
    issue_req(1'b0, `CTRL_BASE + `REG_FETCH_EN, '0, '0);
    issue_req(1'b0, `CTRL_BASE + `REG_SCRATCH, '0, '0);
    issue_req(1'b0, `CTRL_BASE + `REG_EOC, '0, '0);

    // Characters and line ends on every core
    for (int c = 0; c < `PERIPH_N_CORES; c++) begin
      put_char(c, 8'h48);
      put_char(c, 8'h69);
      read_count(c);
      put_char(c, 8'h0A);
      read_count(c);
    end

    // Back-to-back burst that saturates one count
    for (int i = 0; i < SAT_CHARS; i++) begin
      put_char(1, 8'h2E);
    end
    read_count(1);
    put_char(1, 8'h0A);
    read_count(1);

    issue_req(1'b1, `CTRL_BASE + `REG_EOC, 32'h0000_002A, 4'hF);
    issue_req(1'b0, `CTRL_BASE + `REG_EOC, '0, '0);

    // Random bursts with idle gaps
    for (int n = 0; n < N_RANDOM; ) begin
      int unsigned len;
      len = 1 + $urandom_range(5);
      for (int k = 0; k < len && n < N_RANDOM; k++) begin
        random_request();
        n++;
      end
      repeat ($urandom_range(MAX_GAP)) step_idle();
    end

    drain();
    repeat (8) step_idle();
    if (n_rsp_seen == n_req) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("%0d requests issued but %0d responses seen", n_req, n_rsp_seen);
      $display("Regression failed");
      $fatal(1, "response count mismatch");
    end
  end

endmodule

/* rtl/periph_subsys.sv */
// Peripheral subsystem top level
// Request queue, APB bridge, control registers and stdout port

`timescale 1ns/1ns
`include "periph_consts.svh"

module periph_subsys
  import periph_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_valid_i,
  input  logic                       req_write_i,
  input  addr_t                      req_addr_i,
  input  data_t                      req_wdata_i,
  input  strb_t                      req_strb_i,
  output logic                       rsp_valid_o,
  output data_t                      rsp_rdata_o,
  output logic                       rsp_err_o,
  output logic [`PERIPH_N_CORES-1:0] fetch_en_o,
  output logic                       eoc_o,
  output data_t                      exit_code_o,
  output logic                       char_valid_o,
  output core_id_t                   char_core_o,
  output logic [7:0]                 char_data_o,
  output logic                       line_end_o
);

  // Queue head
  logic  not_empty;
  logic  pop;
  logic  head_write;
  addr_t head_addr;
  data_t head_wdata;
  strb_t head_strb;

  // APB, slave 0 control and slave 1 stdout
  addr_t      paddr;
  logic       pwrite;
  data_t      pwdata;
  strb_t      pstrb;
  logic [1:0] psel;
  logic       penable;
  data_t      prdata0;
  logic       pslverr0;
  data_t      prdata1;
  logic       pslverr1;

  req_fifo i_req_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (req_valid_i),
    .write_i      (req_write_i),
    .addr_i       (req_addr_i),
    .wdata_i      (req_wdata_i),
    .strb_i       (req_strb_i),
    .pop_i        (pop),
    .not_empty_o  (not_empty),
    .head_write_o (head_write),
    .head_addr_o  (head_addr),
    .head_wdata_o (head_wdata),
    .head_strb_o  (head_strb)
  );

  apb_bridge i_apb_bridge (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .not_empty_i  (not_empty),
    .head_write_i (head_write),
    .head_addr_i  (head_addr),
    .head_wdata_i (head_wdata),
    .head_strb_i  (head_strb),
    .pop_o        (pop),
    .paddr_o      (paddr),
    .pwrite_o     (pwrite),
    .pwdata_o     (pwdata),
    .pstrb_o      (pstrb),
    .psel_o       (psel),
    .penable_o    (penable),
    .prdata0_i    (prdata0),
    .pslverr0_i   (pslverr0),
    .prdata1_i    (prdata1),
    .pslverr1_i   (pslverr1),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o)
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .psel_i      (psel[0]),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .pstrb_i     (pstrb),
    .prdata_o    (prdata0),
    .pslverr_o   (pslverr0),
    .fetch_en_o  (fetch_en_o),
    .eoc_o       (eoc_o),
    .exit_code_o (exit_code_o)
  );

  apb_stdout i_stdout (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .psel_i       (psel[1]),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata1),
    .pslverr_o    (pslverr1),
    .char_valid_o (char_valid_o),
    .char_core_o  (char_core_o),
    .char_data_o  (char_data_o),
    .line_end_o   (line_end_o)
  );

endmodule

/* rtl/apb_stdout.sv */
// Stdout port on APB
// Per-core character strobes, line end pulses and
// saturating pending character counts readable per core

`timescale 1ns/1ns
`include "periph_consts.svh"

module apb_stdout
  import periph_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     psel_i,
  input  logic     penable_i,
  input  logic     pwrite_i,
  input  addr_t    paddr_i,
  input  data_t    pwdata_i,
  output data_t    prdata_o,
  output logic     pslverr_o,
  output logic     char_valid_o,
  output core_id_t char_core_o,
  output logic [7:0] char_data_o,
  output logic     line_end_o
);

  logic [11:0] offset;
  logic [7:0]  slot;
  core_id_t    core;
  logic        bad;
  logic        wr_en;

  cnt_t        cnt_q [`PERIPH_N_CORES];
  logic        char_valid_q;
  logic        line_end_q;
  core_id_t    char_core_q;
  logic [7:0]  char_data_q;

  // One 16-byte slot per core
  assign offset = paddr_i[11:0];
  assign slot   = offset[11:4];
  assign core   = core_id_t'(slot);
  assign bad    = (offset[3:0] != 4'h0) || (slot >= 8'(`PERIPH_N_CORES));

  assign pslverr_o = bad;
  assign prdata_o  = (bad || pwrite_i) ? '0 : data_t'(cnt_q[core]);
  assign wr_en     = psel_i && penable_i && pwrite_i && !bad;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      char_core_q <= core;
      char_data_q <= pwdata_i[7:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      char_valid_q <= 1'b0;
      line_end_q   <= 1'b0;
      for (int c = 0; c < `PERIPH_N_CORES; c++) begin
        cnt_q[c] <= '0;
      end
    end else begin
      char_valid_q <= wr_en;
      line_end_q   <= wr_en && (pwdata_i[7:0] == 8'h0A);
      if (wr_en) begin
        if (pwdata_i[7:0] == 8'h0A) begin
          cnt_q[core] <= '0;
        end else if (cnt_q[core] != '1) begin
          cnt_q[core] <= cnt_q[core] + 1'b1;
        end
      end
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_core_o  = char_core_q;
  assign char_data_o  = char_data_q;
  assign line_end_o   = line_end_q;

endmodule

/* rtl/soc_ctrl_regs.sv */
// SoC control register block on APB
// Info, fetch enable, scratch and end-of-computation registers

`timescale 1ns/1ns
`include "periph_consts.svh"

module soc_ctrl_regs
  import periph_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  addr_t                      paddr_i,
  input  data_t                      pwdata_i,
  input  strb_t                      pstrb_i,
  output data_t                      prdata_o,
  output logic                       pslverr_o,
  output logic [`PERIPH_N_CORES-1:0] fetch_en_o,
  output logic                       eoc_o,
  output data_t                      exit_code_o
);

  localparam int unsigned HALF = `PERIPH_DW / 2;
  // Clusters in the upper half, cores in the lower
  localparam data_t INFO_VAL = {HALF'(`PERIPH_N_CLUSTERS), HALF'(`PERIPH_N_CORES)};

  logic [11:0]                offset;
  logic                       wr_en;
  logic [`PERIPH_N_CORES-1:0] fetch_en_q;
  data_t                      scratch_q;
  logic                       eoc_q;
  data_t                      exit_code_q;

  assign offset = paddr_i[11:0];

  // Read mux and error decode, data only on reads
  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    case (offset)
      `REG_INFO: begin
        if (pwrite_i) begin
          pslverr_o = 1'b1;
        end else begin
          prdata_o = INFO_VAL;
        end
      end
      `REG_FETCH_EN: begin
        if (!pwrite_i) begin
          prdata_o = data_t'(fetch_en_q);
        end
      end
      `REG_SCRATCH: begin
        if (!pwrite_i) begin
          prdata_o = scratch_q;
        end
      end
      `REG_EOC: begin
        if (!pwrite_i) begin
          prdata_o = exit_code_q;
        end
      end
      default: pslverr_o = 1'b1;
    endcase
  end

  assign wr_en = psel_i && penable_i && pwrite_i && !pslverr_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q  <= '0;
      scratch_q   <= '0;
      eoc_q       <= 1'b0;
      exit_code_q <= '0;
    end else if (wr_en) begin
      case (offset)
        `REG_FETCH_EN: fetch_en_q <= pwdata_i[`PERIPH_N_CORES-1:0];
        `REG_SCRATCH: begin
          for (int b = 0; b < `PERIPH_DW / 8; b++) begin
            if (pstrb_i[b]) begin
              scratch_q[8*b +: 8] <= pwdata_i[8*b +: 8];
            end
          end
        end
        `REG_EOC: begin
          // Flag stays set until reset
          eoc_q       <= 1'b1;
          exit_code_q <= pwdata_i;
        end
        default: ;
      endcase
    end
  end

  assign fetch_en_o  = fetch_en_q;
  assign eoc_o       = eoc_q;
  assign exit_code_o = exit_code_q;

  // An access phase here needs a setup phase here the cycle before
  a_access_after_setup: assert property (@(posedge clk_i) disable iff (rst_i)
    (psel_i && penable_i) |-> $past(psel_i && !penable_i))
    else $error("control block accessed without setup");

endmodule

/* rtl/apb_bridge.sv */
// APB master for queued host requests
// Two-rule address decode, IDLE/SETUP/ACCESS FSM and
// single-cycle response strobe with read data and error

`timescale 1ns/1ns
`include "periph_consts.svh"

module apb_bridge
  import periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       not_empty_i,
  input  logic       head_write_i,
  input  addr_t      head_addr_i,
  input  data_t      head_wdata_i,
  input  strb_t      head_strb_i,
  output logic       pop_o,
  output addr_t      paddr_o,
  output logic       pwrite_o,
  output data_t      pwdata_o,
  output strb_t      pstrb_o,
  output logic [1:0] psel_o,
  output logic       penable_o,
  input  data_t      prdata0_i,
  input  logic       pslverr0_i,
  input  data_t      prdata1_i,
  input  logic       pslverr1_i,
  output logic       rsp_valid_o,
  output data_t      rsp_rdata_o,
  output logic       rsp_err_o
);

  apb_state_e state_q;
  apb_state_e state_d;

  // Request taken from the queue head
  logic  write_q;
  addr_t addr_q;
  data_t wdata_q;
  strb_t strb_q;

  logic [1:0] rule_hit;
  data_t      sel_rdata;
  logic       sel_err;

  logic  rsp_valid_q;
  data_t rsp_rdata_q;
  logic  rsp_err_q;

  assign rule_hit[0] = (addr_q >= `CTRL_BASE) && (addr_q <= `CTRL_END);
  assign rule_hit[1] = (addr_q >= `STDOUT_BASE) && (addr_q <= `STDOUT_END);

  assign pop_o = (state_q == IDLE) && not_empty_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (not_empty_i) begin
          state_d = SETUP;
        end
      end
      SETUP:   state_d = ACCESS;
      ACCESS:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Shared APB lines, select only for a matching rule
  assign paddr_o   = addr_q;
  assign pwrite_o  = write_q;
  assign pwdata_o  = wdata_q;
  assign pstrb_o   = strb_q;
  assign psel_o    = (state_q != IDLE) ? rule_hit : 2'b00;
  assign penable_o = (state_q == ACCESS) && (rule_hit != 2'b00);

  // Unmapped requests answer with an error
  always_comb begin
    sel_rdata = '0;
    sel_err   = 1'b1;
    if (rule_hit[0]) begin
      sel_rdata = prdata0_i;
      sel_err   = pslverr0_i;
    end else if (rule_hit[1]) begin
      sel_rdata = prdata1_i;
      sel_err   = pslverr1_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      write_q <= head_write_i;
      addr_q  <= head_addr_i;
      wdata_q <= head_wdata_i;
      strb_q  <= head_strb_i;
    end
    if (state_q == ACCESS) begin
      rsp_err_q   <= sel_err;
      rsp_rdata_q <= sel_err ? '0 : sel_rdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= (state_q == ACCESS);
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

  a_psel_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(psel_o))
    else $error("more than one APB slave selected");

  // Access phase keeps the slave picked in setup
  a_penable_sel: assert property (@(posedge clk_i) disable iff (rst_i)
    penable_o |-> (psel_o != 2'b00) && $stable(psel_o) && !$past(penable_o))
    else $error("penable without a preceding setup phase");

endmodule

/* rtl/req_fifo.sv */
// Request queue between the host strobes and the APB bridge
// Circular buffer with read/write pointers and a fill count,
// plus overflow and underflow checks

`timescale 1ns/1ns
`include "periph_consts.svh"

module req_fifo
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  push_i,
  input  logic  write_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t strb_i,
  input  logic  pop_i,
  output logic  not_empty_o,
  output logic  head_write_o,
  output addr_t head_addr_o,
  output data_t head_wdata_o,
  output strb_t head_strb_o
);

  localparam int unsigned DEPTH = `REQ_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  logic  ent_write_q [DEPTH];
  addr_t ent_addr_q  [DEPTH];
  data_t ent_wdata_q [DEPTH];
  strb_t ent_strb_q  [DEPTH];

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count_q == CNT_W'(DEPTH));
  assign not_empty_o = (count_q != '0);

  assign head_write_o = ent_write_q[rd_ptr_q];
  assign head_addr_o  = ent_addr_q[rd_ptr_q];
  assign head_wdata_o = ent_wdata_q[rd_ptr_q];
  assign head_strb_o  = ent_strb_q[rd_ptr_q];

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      ent_write_q[wr_ptr_q] <= write_i;
      ent_addr_q[wr_ptr_q]  <= addr_i;
      ent_wdata_q[wr_ptr_q] <= wdata_i;
      ent_strb_q[wr_ptr_q]  <= strb_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Count holds when both happen together
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Host keeps its outstanding requests within the queue depth
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> (!full || pop_i))
    else $error("request queue overflow");

  // Bridge only takes a request that is there
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> not_empty_o)
    else $error("request queue underflow");

endmodule

/* rtl/periph_pkg.sv */
// Types for the peripheral subsystem
// Bus address, data and strobe vectors, core index,
// pending character count and the APB bridge phases

`include "periph_consts.svh"

package periph_pkg;

  typedef logic [`PERIPH_AW-1:0]   addr_t;
  typedef logic [`PERIPH_DW-1:0]   data_t;
  typedef logic [`PERIPH_DW/8-1:0] strb_t;

  // Four cores need two index bits
  typedef logic [1:0] core_id_t;
  typedef logic [7:0] cnt_t;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

endpackage

/* include/periph_consts.svh */
// Shared constants for the peripheral subsystem
// Bus widths, core and cluster counts, address map windows,
// control register offsets and request queue depth

`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus widths
`define PERIPH_AW 32
`define PERIPH_DW 32

// Platform size
`define PERIPH_N_CORES    4
`define PERIPH_N_CLUSTERS 1

// Address map, rule 0 is the control block and rule 1 the stdout port
`define CTRL_BASE   32'h1A10_4000
`define CTRL_END    32'h1A10_4FFF
`define STDOUT_BASE 32'h1A10_F000
`define STDOUT_END  32'h1A10_FFFF

// Control register offsets inside the 4 KiB window
`define REG_INFO     12'h000
`define REG_FETCH_EN 12'h004
`define REG_SCRATCH  12'h008
`define REG_EOC      12'h00C

`define REQ_DEPTH 4

`endif
